// ==== verilog/mem_stage_pkg.sv ====
/*
 * memory stage shared types
 * opcode enum, pipeline structs and width constants used by the
 * memory-access stage of the 64-bit pipeline
 */
`default_nettype none

package mem_stage_pkg;

    parameter int xlen = 64;            // data and address width

    // stage opcodes, decoded upstream
    typedef enum logic [3:0] {
        op_none,
        op_alu,                         // rd <- alu result
        op_link,                        // rd <- pc+4
        op_csr,                         // rd <- old csr value in src2
        op_nowb,                        // branches, no write
        op_lb, op_lh, op_lw, op_ld,
        op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd
    } mem_op_t;

    // item from execute
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        mem_op_t         op;
        logic [4:0]      rd;
        logic [4:0]      rs2;           // store data source reg
        logic [xlen-1:0] alu_out;       // address for ld/st
        logic [xlen-1:0] src2;          // store data or csr value
    } ex_mem_t;

    // bypass from writeback
    typedef struct packed {
        logic            wen;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_fwd_t;

    // item to writeback
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            wen;
        logic [xlen-1:0] wdata;
    } mem_wb_t;

    // request to data memory
    typedef struct packed {
        logic            req;
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;         // already on its byte lanes
        logic [7:0]      wmask;         // one bit per byte
    } dmem_req_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

endpackage

`default_nettype wire

// ==== verilog/mem_stage_reg.sv ====
/*
 * execute to memory pipeline register
 * captures the execute item when load is high, holds it otherwise
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_reg
    import mem_stage_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     load,               // ex_ready from the top
    input  ex_mem_t d,
    output ex_mem_t q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;                    // invalid, op_none
        end else if (load) begin
            q <= d;
        end
        // else hold while stalled
    end

    // ************************************************************************
    // checks
    // ************************************************************************

    // no item survives a reset
    a_reset_clears: assert property (@(posedge clk) rst |=> !q.valid)
        else $error("mem_stage_reg: q.valid set after reset");

endmodule

`default_nettype wire

// ==== verilog/store_align.sv ====
/*
 * store path
 * store data bypass from writeback, lane placement and byte mask,
 * builds the request for the data memory
 */
`timescale 1ns/1ps
`default_nettype none

module store_align
    import mem_stage_pkg::*;
(
    input  ex_mem_t   cur,
    input  wb_fwd_t   wb_fwd,
    output dmem_req_t req
);

    logic            st;                // valid store
    logic            ld;                // valid load
    logic            fwd_hit;
    logic [xlen-1:0] sdata;             // store data after bypass
    logic [2:0]      a;                 // low address bits

    assign st = cur.valid && is_store(cur.op);
    assign ld = cur.valid && is_load(cur.op);
    assign a  = cur.alu_out[2:0];

    // writeback is about to write the reg this store reads, x0 never bypassed
    assign fwd_hit = st && wb_fwd.wen && (wb_fwd.rd == cur.rs2) && (cur.rs2 != 5'd0);
    assign sdata   = fwd_hit ? wb_fwd.data : cur.src2;

    always_comb begin
        req       = '0;
        req.req   = st || ld;
        req.we    = st;
        req.addr  = cur.alu_out;
        if (st) begin
            case (cur.op)
                op_sb: begin
                    req.wdata = {56'd0, sdata[7:0]} << {a, 3'b000};
                    req.wmask = 8'h01 << a;
                end
                op_sh: begin
                    req.wdata = {48'd0, sdata[15:0]} << {a[2:1], 4'b0000};
                    req.wmask = 8'h03 << {a[2:1], 1'b0};
                end
                op_sw: begin
                    req.wdata = {32'd0, sdata[31:0]} << {a[2], 5'b00000};
                    req.wmask = 8'h0f << {a[2], 2'b00};
                end
                default: begin          // op_sd, whole word
                    req.wdata = sdata;
                    req.wmask = 8'hff;
                end
            endcase
        end
    end

    // misaligned stores are not handled by the lane logic above
    always_comb begin
        if (st) begin
            a_store_aligned: assert ((cur.op == op_sb) ||
                                     (cur.op == op_sh && a[0] == 1'b0) ||
                                     (cur.op == op_sw && a[1:0] == 2'b00) ||
                                     (cur.op == op_sd && a == 3'b000))
                else $error("store_align: misaligned store at %h", cur.alu_out);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/data_mem.sv ====
/*
 * data memory
 * word array with byte-masked write, one cycle of access latency
 */
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import mem_stage_pkg::*;
#(
    parameter int dmem_words = 256      // power of two
)(
    input  wire             clk,
    input  wire             rst,
    input  dmem_req_t       req,
    output logic            done,
    output logic [xlen-1:0] rdata
);

    localparam int aw = $clog2(dmem_words);

    typedef enum logic {
        dm_idle,                        // waiting for a request
        dm_done                         // result valid, write commits
    } dm_state_t;

    dm_state_t       state;
    logic [xlen-1:0] mem [dmem_words];
    logic [aw-1:0]   idx;

    assign idx  = req.addr[aw+2:3];     // word index, wraps at dmem_words
    assign done = (state == dm_done);

    // ************************************************************************
    // access fsm
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dm_idle;
        end else begin
            case (state)
                dm_idle: if (req.req) state <= dm_done;
                default: state <= dm_idle;          // done lasts one cycle
            endcase
        end
    end

    // read word latched on the way into dm_done
    always_ff @(posedge clk) begin
        if (state == dm_idle && req.req) begin
            rdata <= mem[idx];
        end
    end

    // masked write at the edge closing dm_done
    always_ff @(posedge clk) begin
        if (state == dm_done && req.req && req.we) begin
            for (int i = 0; i < 8; i++) begin
                if (req.wmask[i]) mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
    end

    // a held request must go back through dm_idle before the next done
    a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("data_mem: done high for two cycles");

endmodule

`default_nettype wire

// ==== verilog/load_extend.sv ====
/*
 * load path
 * picks the byte, halfword or word lane from the memory word and
 * sign or zero extends it
 */
`timescale 1ns/1ps
`default_nettype none

module load_extend
    import mem_stage_pkg::*;
(
    input  mem_op_t         op,
    input  wire [2:0]       addr_low,
    input  wire [xlen-1:0]  raw,
    output logic [xlen-1:0] value
);

    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;

    // lane extraction
    assign b = raw[8*addr_low +: 8];
    assign h = raw[16*addr_low[2:1] +: 16];
    assign w = raw[32*addr_low[2] +: 32];

    always_comb begin
        case (op)
            op_lb:   value = {{56{b[7]}}, b};
            op_lh:   value = {{48{h[15]}}, h};
            op_lw:   value = {{32{w[31]}}, w};
            op_lbu:  value = {56'd0, b};
            op_lhu:  value = {48'd0, h};
            op_lwu:  value = {32'd0, w};
            op_ld:   value = raw;                   // full word as is
            default: value = '0;                    // not a load
        endcase
    end

    // halfword and word lanes ignore the low bits, misaligned would read wrong data
    always_comb begin
        if (op == op_lh || op == op_lhu) begin
            a_load_aligned_h: assert (addr_low[0] == 1'b0)
                else $error("load_extend: misaligned halfword load");
        end
        if (op == op_lw || op == op_lwu) begin
            a_load_aligned_w: assert (addr_low[1:0] == 2'b00)
                else $error("load_extend: misaligned word load");
        end
        if (op == op_ld) begin
            a_load_aligned_d: assert (addr_low == 3'b000)
                else $error("load_extend: misaligned doubleword load");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/writeback_select.sv ====
/*
 * writeback select
 * picks the register write value and enable for the current item,
 * drives zero while the stage is blocked
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_select
    import mem_stage_pkg::*;
(
    input  ex_mem_t         cur,
    input  wire             blocked,
    input  wire [xlen-1:0]  load_value,
    output mem_wb_t         out
);

    always_comb begin
        out = '0;
        if (cur.valid && !blocked) begin
            out.valid = 1'b1;
            out.pc    = cur.pc;
            out.rd    = cur.rd;             // passed on even without a write
            case (cur.op)
                op_alu: begin
                    out.wen   = 1'b1;
                    out.wdata = cur.alu_out;
                end
                op_link: begin
                    out.wen   = 1'b1;
                    out.wdata = cur.pc + 64'd4;     // return address
                end
                op_csr: begin
                    out.wen   = 1'b1;
                    out.wdata = cur.src2;   // old csr value
                end
                default: begin
                    if (is_load(cur.op)) begin
                        out.wen   = 1'b1;
                        out.wdata = load_value;
                    end
                    // stores, nowb, none leave wen low
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
/*
 * memory access stage, top level
 * pipeline register, store path, data memory, load path and
 * writeback select, plus the stall towards execute
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import mem_stage_pkg::*;
#(
    parameter int dmem_words = 256
)(
    input  wire     clk,
    input  wire     rst,
    input  ex_mem_t ex_in,
    output logic    ex_ready,
    input  wb_fwd_t wb_fwd,
    output mem_wb_t wb_out,
    input  wire     wb_ready
);

    ex_mem_t         cur;               // registered item
    dmem_req_t       dreq;
    logic            done;
    logic [xlen-1:0] raw;               // word from memory
    logic [xlen-1:0] load_value;
    logic            blocked;
    mem_op_t         ld_op;

    // ************************************************************************
    // stall
    // ************************************************************************

    // memory ops wait one cycle for done
    assign blocked  = cur.valid && (is_load(cur.op) || is_store(cur.op)) && !done;
    assign ex_ready = !blocked && wb_ready;

    assign ld_op = cur.valid ? cur.op : op_none;    // stale ops stay out of the load path

    mem_stage_reg u_reg (
        .clk  (clk),
        .rst  (rst),
        .load (ex_ready),
        .d    (ex_in),
        .q    (cur)
    );

    store_align u_store (
        .cur    (cur),
        .wb_fwd (wb_fwd),
        .req    (dreq)
    );

    data_mem #(
        .dmem_words (dmem_words)
    ) u_dmem (
        .clk   (clk),
        .rst   (rst),
        .req   (dreq),
        .done  (done),
        .rdata (raw)
    );

    load_extend u_load (
        .op       (ld_op),
        .addr_low (cur.alu_out[2:0]),
        .raw      (raw),
        .value    (load_value)
    );

    writeback_select u_wb (
        .cur        (cur),
        .blocked    (blocked),
        .load_value (load_value),
        .out        (wb_out)
    );

endmodule

`default_nettype wire

// ==== sim/mem_stage_tb.sv ====
/*
 * memory stage testbench
 * drives execute items into the stage, keeps a byte image of the data
 * memory and checks wb_out and ex_ready with concurrent assertions
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int wbw   = $bits(mem_wb_t);
    localparam int limit = 20;              // cycles before a wait gives up

    logic    clk;
    logic    rst;
    ex_mem_t ex_in;
    logic    ex_ready;
    wb_fwd_t wb_fwd;
    mem_wb_t wb_out;
    logic    wb_ready;

    int          seed = 58;
    logic [63:0] pc_next = 64'h1000;
    logic [7:0]  shadow [2048];             // byte image of dmem
    mem_wb_t     exp_wb;                    // result of the last accepted item
    mem_wb_t     held_wb;                   // wb_out one cycle back
    logic        nm_due;                    // non-mem result due now
    logic        mem_gap;                   // mem op waiting for done
    logic        mem_due;                   // mem op result due now
    mem_op_t     ld_ops [7] = '{op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    mem_op_t     st_ops [4] = '{op_sb, op_sh, op_sw, op_sd};

    mem_stage #(
        .dmem_words (256)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .ex_in    (ex_in),
        .ex_ready (ex_ready),
        .wb_fwd   (wb_fwd),
        .wb_out   (wb_out),
        .wb_ready (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ************************************************************************
    // reference model
    // ************************************************************************

    function automatic int bytes_of(input mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            op_ld, op_sd:         return 8;
            default:              return 0;     // no memory access
        endcase
    endfunction

    function automatic logic writes_mem(input mem_op_t op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    // little endian and sign extended for lb/lh/lw
    function automatic logic [63:0] read_shadow(input mem_op_t op, input logic [63:0] a);
        logic [63:0] v;
        logic [10:0] ix;
        int          n;
        v = '0;
        n = bytes_of(op);
        for (int i = n - 1; i >= 0; i--) begin
            ix = a[10:0] + 11'(i);
            v  = {v[55:0], shadow[ix]};
        end
        if (op inside {op_lb, op_lh, op_lw}) begin
            v = $signed(v << (64 - 8 * n)) >>> (64 - 8 * n);
        end
        return v;
    endfunction

    function automatic mem_wb_t expect_wb(input ex_mem_t it);
        mem_wb_t e;
        e       = '0;
        e.valid = 1'b1;
        e.pc    = it.pc;
        e.rd    = it.rd;
        case (it.op)
            op_alu: begin
                e.wen   = 1'b1;
                e.wdata = it.alu_out;
            end
            op_link: begin
                e.wen   = 1'b1;
                e.wdata = it.pc + 64'd4;
            end
            op_csr: begin
                e.wen   = 1'b1;
                e.wdata = it.src2;
            end
            default: begin
                if (bytes_of(it.op) != 0 && !writes_mem(it.op)) begin
                    e.wen   = 1'b1;
                    e.wdata = read_shadow(it.op, it.alu_out);
                end
            end
        endcase
        return e;
    endfunction

    // store data after the writeback bypass with x0 excluded
    task automatic write_shadow(input ex_mem_t it);
        logic [63:0] d;
        logic [10:0] ix;
        d = it.src2;
        if (wb_fwd.wen && wb_fwd.rd == it.rs2 && it.rs2 != 5'd0) begin
            d = wb_fwd.data;
        end
        for (int i = 0; i < bytes_of(it.op); i++) begin
            ix         = it.alu_out[10:0] + 11'(i);
            shadow[ix] = d[7:0];
            d          = d >> 8;
        end
    endtask

    // acceptance tracking on the values before the edge
    always @(posedge clk) begin
        held_wb <= wb_out;
        if (rst) begin
            nm_due  <= 1'b0;
            mem_gap <= 1'b0;
            mem_due <= 1'b0;
        end else begin
            nm_due  <= 1'b0;
            mem_gap <= 1'b0;
            mem_due <= mem_gap;             // result one cycle after the gap
            if (ex_ready && ex_in.valid) begin
                exp_wb <= expect_wb(ex_in);
                if (bytes_of(ex_in.op) == 0) begin
                    nm_due <= 1'b1;
                end else begin
                    mem_gap <= 1'b1;
                end
                if (writes_mem(ex_in.op)) write_shadow(ex_in);
            end
        end
    end

    // ************************************************************************
    // checks
    // ************************************************************************

    task automatic report_mismatch(input string name, input logic [wbw-1:0] exp,
                                   input logic [wbw-1:0] got);
        $display("CHECK FAILED %s exp %h got %h", name, exp, got);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    endtask

    a_reset_ready: assert property (@(posedge clk) rst |=> ex_ready == wb_ready)
        else report_mismatch("ex_ready", wbw'($sampled(wb_ready)), wbw'($sampled(ex_ready)));
    a_reset_out: assert property (@(posedge clk) rst |=> !wb_out.valid && !wb_out.wen)
        else report_mismatch("wb_out.valid/wen", '0,
                             wbw'({$sampled(wb_out.valid), $sampled(wb_out.wen)}));
    a_nonmem: assert property (@(posedge clk) disable iff (rst) nm_due |-> wb_out == exp_wb)
        else report_mismatch("wb_out", $sampled(exp_wb), $sampled(wb_out));
    a_gap_ready: assert property (@(posedge clk) disable iff (rst) mem_gap |-> !ex_ready)
        else report_mismatch("ex_ready", '0, wbw'($sampled(ex_ready)));
    a_gap_out: assert property (@(posedge clk) disable iff (rst) mem_gap |-> wb_out == '0)
        else report_mismatch("wb_out", '0, $sampled(wb_out));
    a_mem_out: assert property (@(posedge clk) disable iff (rst) mem_due |-> wb_out == exp_wb)
        else report_mismatch("wb_out", $sampled(exp_wb), $sampled(wb_out));
    a_mem_ready: assert property (@(posedge clk) disable iff (rst)
                                  mem_due |-> ex_ready == wb_ready)
        else report_mismatch("ex_ready", wbw'($sampled(wb_ready)), wbw'($sampled(ex_ready)));
    a_bp_ready: assert property (@(posedge clk) disable iff (rst) !wb_ready |-> !ex_ready)
        else report_mismatch("ex_ready", '0, wbw'($sampled(ex_ready)));
    // held item stays put on wb_out
    a_bp_hold: assert property (@(posedge clk) disable iff (rst)
                                (!wb_ready && wb_out.valid) |=> wb_out == held_wb)
        else report_mismatch("wb_out", $sampled(held_wb), $sampled(wb_out));

    // ************************************************************************
    // stimulus
    // ************************************************************************

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // random offset inside a doubleword aligned to n bytes
    function automatic logic [63:0] pick_addr(input int word, input int n);
        int off;
        off = $random(seed) & 7 & ~(n - 1);
        return 64'(word * 8 + off);
    endfunction

    task automatic drive(input mem_op_t op, input logic [63:0] a, input logic [63:0] s2,
                         input logic [4:0] rs2);
        ex_mem_t it;
        it         = '0;
        it.valid   = 1'b1;
        it.pc      = pc_next;
        it.op      = op;
        it.rd      = 5'($random(seed));
        it.rs2     = rs2;
        it.alu_out = a;
        it.src2    = s2;
        pc_next    = pc_next + 64'd4;
        ex_in     <= it;
    endtask

    task automatic wait_accept();
        int n;
        for (n = 0; n < limit; n++) begin
            @(negedge clk);
            if (ex_ready) break;
        end
        if (n == limit) begin
            timeout_fail("ex_ready to take an item");
        end else begin
            @(posedge clk);                 // item taken at this edge
            ex_in <= '0;
        end
    endtask

    task automatic send(input mem_op_t op, input logic [63:0] a, input logic [63:0] s2,
                        input logic [4:0] rs2);
        drive(op, a, s2, rs2);
        wait_accept();
    endtask

    initial begin
        logic [63:0] a;
        logic [1:0]  k;
        logic [2:0]  j;
        int          word;
        int          n;
        rst      <= 1'b1;
        drive(op_alu, rand64(), rand64(), 5'd0);    // must not get past reset
        wb_fwd   <= '0;
        wb_ready <= 1'b1;

        // 3 reset cycles with wb_ready toggled so ex_ready must follow it
        @(posedge clk);
        wb_ready <= 1'b0;
        @(posedge clk);
        wb_ready <= 1'b1;
        @(posedge clk);
        rst   <= 1'b0;
        ex_in <= '0;
        @(posedge clk);

        for (int i = 0; i < 4; i++) begin
            send(op_alu, rand64(), rand64(), 5'd0);
            send(op_link, rand64(), rand64(), 5'd0);
            send(op_csr, rand64(), rand64(), 5'd0);
            send(op_nowb, rand64(), rand64(), 5'd0);
        end

        for (int i = 0; i < 8; i++) begin
            send(op_sd, 64'(i * 8), rand64(), 5'd0);    // fill the 64-byte window
        end

        // each store followed by every load kind in the same doubleword
        for (int i = 0; i < 16; i++) begin
            k    = 2'(i);                   // every store size in turn
            word = $random(seed) & 7;
            send(st_ops[k], pick_addr(word, bytes_of(st_ops[k])), rand64(), 5'($random(seed)));
            for (j = 0; j < 7; j++) begin
                send(ld_ops[j], pick_addr(word, bytes_of(ld_ops[j])), rand64(), 5'd0);
            end
        end

        // writeback bypass with wb_fwd held until the store has written
        a = pick_addr(3, 8);
        wb_fwd <= {1'b1, 5'd5, rand64()};  // rd matches rs2
        send(op_sd, a, rand64(), 5'd5);
        send(op_ld, a, 64'd0, 5'd0);
        wb_fwd <= {1'b1, 5'd0, rand64()};  // x0
        send(op_sd, a, rand64(), 5'd0);
        send(op_ld, a, 64'd0, 5'd0);
        wb_fwd <= {1'b0, 5'd9, rand64()};  // no write in writeback
        send(op_sw, a + 64'd4, rand64(), 5'd9);
        send(op_ld, a, 64'd0, 5'd0);

        // back-pressure while an alu item sits in the register
        wb_fwd <= '0;
        send(op_alu, rand64(), rand64(), 5'd0);
        wb_ready <= 1'b0;
        drive(op_link, rand64(), rand64(), 5'd0);
        repeat (4) @(posedge clk);
        wb_ready <= 1'b1;
        wait_accept();

        for (n = 0; n < limit; n++) begin
            @(negedge clk);
            if (!nm_due && !mem_gap && !mem_due) break;
        end
        if (n == limit) begin
            timeout_fail("the last result");
        end else begin
            @(posedge clk);
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/mem_stage_pkg.sv
verilog/mem_stage_reg.sv
verilog/store_align.sv
verilog/data_mem.sv
verilog/load_extend.sv
verilog/writeback_select.sv
verilog/mem_stage.sv
sim/mem_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_stage_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vmem_stage_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
